//--- source/pwr_pkg.sv
// always-on power and interrupt definitions
// domain indexes, power commands, control bits and interrupt vector layout
`default_nettype none

package pwr_pkg;

  // domains
  localparam int NUM_BANKS   = 4;
  localparam int NUM_DOMAINS = NUM_BANKS + 2;
  localparam int DOM_CPU     = 0;
  localparam int DOM_PERIPH  = 1;
  localparam int DOM_W       = 3;

  // command buffer and sender credits
  localparam int CMD_DEPTH  = 4;
  localparam int CMD_PTR_W  = $clog2(CMD_DEPTH);
  localparam int CMD_CNT_W  = $clog2(CMD_DEPTH + 1);

  // interrupt vector as the core sees it
  localparam int IRQ_W         = 32;
  localparam int NUM_FAST      = 15;
  localparam int IRQ_SW_BIT    = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXT_BIT   = 11;
  localparam int IRQ_FAST_BASE = 16;

  // fast line positions inside the fast group
  localparam int FAST_TIMER1    = 0;
  localparam int FAST_TIMER2    = 1;
  localparam int FAST_TIMER3    = 2;
  localparam int FAST_DMA       = 3;
  localparam int FAST_SPI       = 4;
  localparam int FAST_SPI_FLASH = 5;
  localparam int FAST_GPIO_AO   = 6;
  localparam int NUM_GPIO_AO    = 8;

  typedef enum logic [1:0] {
    PWR_ON     = 2'd0,
    PWR_OFF    = 2'd1,
    PWR_RETAIN = 2'd2
  } pwr_op_e;

  typedef struct packed {
    logic [DOM_W-1:0] dom;
    pwr_op_e          op;
  } pwr_cmd_t;

  // all active low, all high while the domain runs
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

endpackage

`default_nettype wire

//--- source/intr_aggregator.sv
// interrupt aggregator
// registers the core interrupt vector and holds fast lines until acknowledged
`timescale 1ns/1ps
`default_nettype none

module intr_aggregator
  import pwr_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   irq_software_i,
  input  logic                   irq_external_i,
  input  logic [3:0]             timer_intr_i,
  input  logic                   dma_done_intr_i,
  input  logic                   spi_intr_i,
  input  logic                   spi_flash_intr_i,
  input  logic [NUM_GPIO_AO-1:0] gpio_ao_intr_i,
  input  logic                   irq_ack_i,
  input  logic [4:0]             irq_id_i,
  output logic [IRQ_W-1:0]       irq_o,
  output logic                   wake_o
);

  logic [NUM_FAST-1:0] fast_src;
  logic [IRQ_W-1:0]    irq_d;
  logic [IRQ_W-1:0]    irq_q;

  always_comb begin
    fast_src                                = '0;
    fast_src[FAST_TIMER1]                   = timer_intr_i[1];
    fast_src[FAST_TIMER2]                   = timer_intr_i[2];
    fast_src[FAST_TIMER3]                   = timer_intr_i[3];
    fast_src[FAST_DMA]                      = dma_done_intr_i;
    fast_src[FAST_SPI]                      = spi_intr_i;
    fast_src[FAST_SPI_FLASH]                = spi_flash_intr_i;
    fast_src[FAST_GPIO_AO +: NUM_GPIO_AO]   = gpio_ao_intr_i;
  end

  always_comb begin
    irq_d                = '0;
    // level sources land straight in their bits
    irq_d[IRQ_SW_BIT]    = irq_software_i;
    irq_d[IRQ_TIMER_BIT] = timer_intr_i[0];
    irq_d[IRQ_EXT_BIT]   = irq_external_i;
    for (int i = 0; i < NUM_FAST; i++) begin
      if (irq_ack_i && (irq_id_i == 5'(IRQ_FAST_BASE + i))) begin
        irq_d[IRQ_FAST_BASE + i] = fast_src[i];
      end else begin
        irq_d[IRQ_FAST_BASE + i] = fast_src[i] | irq_q[IRQ_FAST_BASE + i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o  = irq_q;
  // any visible interrupt may wake the cpu
  assign wake_o = |irq_q;

endmodule

`default_nettype wire

//--- source/pwr_cmd_fifo.sv
// power command FIFO
// holds CMD_DEPTH commands, the sender's credits keep it from overflowing
`timescale 1ns/1ps
`default_nettype none

module pwr_cmd_fifo
  import pwr_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  pwr_cmd_t cmd_i,
  input  logic     pop_i,
  output pwr_cmd_t head_o,
  output logic     valid_o
);

  pwr_cmd_t             mem_q [CMD_DEPTH];
  logic [CMD_PTR_W-1:0] wr_ptr_q;
  logic [CMD_PTR_W-1:0] rd_ptr_q;
  logic [CMD_CNT_W-1:0] count_q;
  logic                 do_pop;

  assign do_pop = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);

  // sender must hold a credit for every push
  a_no_push_when_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count_q != CMD_CNT_W'(CMD_DEPTH)))
    else $error("command pushed into a full FIFO");

endmodule

`default_nettype wire

//--- source/domain_sequencer.sv
// power domain sequencer
// steps clock gate, isolation, retention, reset and switch in a safe order
`timescale 1ns/1ps
`default_nettype none

module domain_sequencer
  import pwr_pkg::*;
#(
  parameter bit RETENTIVE = 1'b0
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  pwr_op_e       op_i,
  input  logic          ack_n_i,
  output pwr_ctrl_out_t ctrl_o,
  output logic          busy_o,
  output logic          off_o
);

  typedef enum logic [3:0] {
    S_IDLE, S_NOP,
    S_CLK_OFF, S_ISO_ON, S_RET_ON, S_RST_ON, S_SW_OFF, S_WAIT_OFF,
    S_SW_ON, S_WAIT_ON, S_RST_OFF, S_RET_OFF, S_ISO_OFF, S_CLK_ON
  } seq_state_e;

  typedef enum logic [1:0] {D_ON, D_OFF, D_RET} dom_state_e;

  seq_state_e    state_q;
  dom_state_e    dom_q;
  pwr_ctrl_out_t ctrl_q;
  logic          ret_q;
  logic          want_ret;

  // retain only makes sense where the memory can hold its contents
  assign want_ret = RETENTIVE && (op_i == PWR_RETAIN);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      dom_q   <= D_ON;
      ctrl_q  <= '1;
      ret_q   <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            if (op_i == PWR_ON) begin
              if (dom_q != D_ON) begin
                state_q <= S_SW_ON;
                dom_q   <= D_ON;
              end else begin
                state_q <= S_NOP;
              end
            end else if (dom_q == D_ON) begin
              state_q <= S_CLK_OFF;
              ret_q   <= want_ret;
            end else if ((dom_q == D_RET) && !want_ret) begin
              // retained already, only the switch is left
              state_q <= S_SW_OFF;
            end else begin
              state_q <= S_NOP;
            end
          end
        end
        S_NOP: state_q <= S_IDLE;
        S_CLK_OFF: begin
          ctrl_q.clkgate_en_n <= 1'b0;
          state_q             <= S_ISO_ON;
        end
        S_ISO_ON: begin
          ctrl_q.isogate_en_n <= 1'b0;
          state_q             <= ret_q ? S_RET_ON : S_RST_ON;
        end
        S_RET_ON: begin
          ctrl_q.retentive_en_n <= 1'b0;
          state_q               <= S_RST_ON;
        end
        S_RST_ON: begin
          ctrl_q.rst_n <= 1'b0;
          if (ret_q) begin
            state_q <= S_IDLE;
            dom_q   <= D_RET;
          end else begin
            state_q <= S_SW_OFF;
          end
        end
        S_SW_OFF: begin
          ctrl_q.pwrgate_en_n <= 1'b0;
          state_q             <= S_WAIT_OFF;
        end
        S_WAIT_OFF: begin
          if (!ack_n_i) begin
            state_q <= S_IDLE;
            dom_q   <= D_OFF;
          end
        end
        S_SW_ON: begin
          ctrl_q.pwrgate_en_n <= 1'b1;
          state_q             <= S_WAIT_ON;
        end
        S_WAIT_ON: begin
          if (ack_n_i) begin
            state_q <= S_RST_OFF;
          end
        end
        S_RST_OFF: begin
          ctrl_q.rst_n <= 1'b1;
          state_q      <= RETENTIVE ? S_RET_OFF : S_ISO_OFF;
        end
        S_RET_OFF: begin
          ctrl_q.retentive_en_n <= 1'b1;
          state_q               <= S_ISO_OFF;
        end
        S_ISO_OFF: begin
          ctrl_q.isogate_en_n <= 1'b1;
          state_q             <= S_CLK_ON;
        end
        S_CLK_ON: begin
          ctrl_q.clkgate_en_n <= 1'b1;
          state_q             <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign ctrl_o = ctrl_q;
  assign busy_o = (state_q != S_IDLE);
  assign off_o  = (dom_q == D_OFF);

  a_iso_while_switched_off : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ctrl_q.pwrgate_en_n |-> !ctrl_q.isogate_en_n)
    else $error("switch off with isolation released");

  a_no_start_while_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> !busy_o)
    else $error("sequencer started while busy");

endmodule

`default_nettype wire

//--- source/power_manager.sv
// power manager control
// dispatches FIFO commands and cpu wake-ups to the domain sequencers
`timescale 1ns/1ps
`default_nettype none

module power_manager
  import pwr_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  pwr_cmd_t               head_i,
  input  logic                   head_valid_i,
  output logic                   pop_o,
  output logic                   credit_o,
  input  logic                   wake_i,
  input  logic [NUM_DOMAINS-1:0] busy_i,
  input  logic                   cpu_off_i,
  output logic [NUM_DOMAINS-1:0] start_o,
  output pwr_op_e                op_o
);

  logic wake_pend_q;
  logic wake_set;
  logic wake_go;
  logic head_ok;
  logic credit_q;

  assign head_ok  = (head_i.dom < DOM_W'(NUM_DOMAINS));
  assign wake_set = wake_i && cpu_off_i && !busy_i[DOM_CPU];

  // one sequencer start per cycle with a pending wake-up ahead of the FIFO head
  always_comb begin
    start_o = '0;
    op_o    = head_i.op;
    pop_o   = 1'b0;
    wake_go = 1'b0;
    if (wake_pend_q && !busy_i[DOM_CPU]) begin
      start_o[DOM_CPU] = 1'b1;
      op_o             = PWR_ON;
      wake_go          = 1'b1;
    end else if (head_valid_i) begin
      if (!head_ok) begin
        // unknown domain is dropped and its credit handed back
        pop_o = 1'b1;
      end else if (!busy_i[head_i.dom]) begin
        start_o[head_i.dom] = 1'b1;
        pop_o               = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wake_pend_q <= 1'b0;
      credit_q    <= 1'b0;
    end else begin
      if (wake_go) begin
        wake_pend_q <= 1'b0;
      end else if (wake_set) begin
        wake_pend_q <= 1'b1;
      end
      credit_q <= pop_o;
    end
  end

  assign credit_o = credit_q;

endmodule

`default_nettype wire

//--- source/mcu_ao_top.sv
// always-on block of the mcu
// command FIFO, power manager, domain sequencers and interrupt aggregator
`timescale 1ns/1ps
`default_nettype none

module mcu_ao_top
  import pwr_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  pwr_cmd_t               cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   credit_o,
  input  logic                   irq_software_i,
  input  logic                   irq_external_i,
  input  logic [3:0]             timer_intr_i,
  input  logic                   dma_done_intr_i,
  input  logic                   spi_intr_i,
  input  logic                   spi_flash_intr_i,
  input  logic [NUM_GPIO_AO-1:0] gpio_ao_intr_i,
  input  logic                   irq_ack_i,
  input  logic [4:0]             irq_id_i,
  output logic [IRQ_W-1:0]       irq_o,
  output pwr_ctrl_out_t          pwr_ctrl_o [NUM_DOMAINS-1:0],
  input  logic [NUM_DOMAINS-1:0] pwr_ack_n_i
);

  pwr_cmd_t               fifo_head;
  logic                   fifo_valid;
  logic                   fifo_pop;
  logic                   wake;
  logic [NUM_DOMAINS-1:0] seq_busy;
  logic [NUM_DOMAINS-1:0] seq_off;
  logic [NUM_DOMAINS-1:0] seq_start;
  pwr_op_e                seq_op;

  pwr_cmd_fifo i_pwr_cmd_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (cmd_valid_i),
    .cmd_i   (cmd_i),
    .pop_i   (fifo_pop),
    .head_o  (fifo_head),
    .valid_o (fifo_valid)
  );

  power_manager i_power_manager (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_i       (fifo_head),
    .head_valid_i (fifo_valid),
    .pop_o        (fifo_pop),
    .credit_o     (credit_o),
    .wake_i       (wake),
    .busy_i       (seq_busy),
    .cpu_off_i    (seq_off[DOM_CPU]),
    .start_o      (seq_start),
    .op_o         (seq_op)
  );

  // banks retain, cpu and peripherals always switch fully off
  for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_dom
    domain_sequencer #(
      .RETENTIVE (i > DOM_PERIPH)
    ) i_domain_sequencer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .start_i (seq_start[i]),
      .op_i    (seq_op),
      .ack_n_i (pwr_ack_n_i[i]),
      .ctrl_o  (pwr_ctrl_o[i]),
      .busy_o  (seq_busy[i]),
      .off_o   (seq_off[i])
    );
  end

  intr_aggregator i_intr_aggregator (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .irq_software_i   (irq_software_i),
    .irq_external_i   (irq_external_i),
    .timer_intr_i     (timer_intr_i),
    .dma_done_intr_i  (dma_done_intr_i),
    .spi_intr_i       (spi_intr_i),
    .spi_flash_intr_i (spi_flash_intr_i),
    .gpio_ao_intr_i   (gpio_ao_intr_i),
    .irq_ack_i        (irq_ack_i),
    .irq_id_i         (irq_id_i),
    .irq_o            (irq_o),
    .wake_o           (wake)
  );

endmodule

`default_nettype wire

//--- test/tb_mcu_ao_top.sv
// testbench for the always-on power and interrupt block
// directed tests with a power switch model per domain
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_ao_top
  import pwr_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic                   clk;
  logic                   rst_n;
  pwr_cmd_t               cmd;
  logic                   cmd_valid;
  logic                   credit;
  logic                   irq_software;
  logic                   irq_external;
  logic [3:0]             timer_intr;
  logic                   dma_done_intr;
  logic                   spi_intr;
  logic                   spi_flash_intr;
  logic [NUM_GPIO_AO-1:0] gpio_ao_intr;
  logic                   irq_ack;
  logic [4:0]             irq_id;
  logic [IRQ_W-1:0]       irq;
  pwr_ctrl_out_t          pwr_ctrl [NUM_DOMAINS-1:0];
  logic [NUM_DOMAINS-1:0] pwr_ack_n = '1;

  integer        seed = 32'h6f8d26e0;
  int unsigned   wait_left [NUM_DOMAINS] = '{default: 0};
  int            pushes_sent = 0;
  int            credits_back = 0;
  pwr_ctrl_out_t exp_q [$];

  mcu_ao_top i_mcu_ao_top (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .cmd_i            (cmd),
    .cmd_valid_i      (cmd_valid),
    .credit_o         (credit),
    .irq_software_i   (irq_software),
    .irq_external_i   (irq_external),
    .timer_intr_i     (timer_intr),
    .dma_done_intr_i  (dma_done_intr),
    .spi_intr_i       (spi_intr),
    .spi_flash_intr_i (spi_flash_intr),
    .gpio_ao_intr_i   (gpio_ao_intr),
    .irq_ack_i        (irq_ack),
    .irq_id_i         (irq_id),
    .irq_o            (irq),
    .pwr_ctrl_o       (pwr_ctrl),
    .pwr_ack_n_i      (pwr_ack_n)
  );

  always #20 clk = ~clk;

  // ack of the switch model follows the switch enable after 1 to 8 cycles
  always @(posedge clk) begin
    #2;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      if (pwr_ack_n[d] === pwr_ctrl[d].pwrgate_en_n) begin
        wait_left[d] = 0;
      end else if (wait_left[d] == 0) begin
        wait_left[d] = ($unsigned($random(seed)) % 8) + 1;
      end else if (wait_left[d] == 1) begin
        pwr_ack_n[d] = pwr_ctrl[d].pwrgate_en_n;
        wait_left[d] = 0;
      end else begin
        wait_left[d] = wait_left[d] - 1;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && credit) begin
      credits_back++;
      if (credits_back > pushes_sent) begin
        abort_run("a credit came back with no command outstanding");
      end
    end
  end

  task automatic abort_run(input string why);
    $display("TESTS FAILED");
    $display("%s", why);
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // final control state once a command has run
  function automatic pwr_ctrl_out_t settled(input pwr_op_e op, input bit retentive);
    pwr_ctrl_out_t v;
    v = '1;
    if (op != PWR_ON) begin
      v.clkgate_en_n = 1'b0;
      v.isogate_en_n = 1'b0;
      v.rst_n        = 1'b0;
      if ((op == PWR_RETAIN) && retentive) begin
        v.retentive_en_n = 1'b0;
      end else begin
        v.pwrgate_en_n = 1'b0;
      end
    end
    return v;
  endfunction

  task automatic expect_power_down(input bit retain);
    pwr_ctrl_out_t v;
    v = '1;
    v.clkgate_en_n = 1'b0;
    exp_q.push_back(v);
    v.isogate_en_n = 1'b0;
    exp_q.push_back(v);
    if (retain) begin
      v.retentive_en_n = 1'b0;
      exp_q.push_back(v);
    end
    v.rst_n = 1'b0;
    exp_q.push_back(v);
    if (!retain) begin
      v.pwrgate_en_n = 1'b0;
      exp_q.push_back(v);
    end
  endtask

  task automatic expect_power_up(input pwr_ctrl_out_t from);
    pwr_ctrl_out_t v;
    v = from;
    if (!v.pwrgate_en_n) begin
      v.pwrgate_en_n = 1'b1;
      exp_q.push_back(v);
    end
    v.rst_n = 1'b1;
    exp_q.push_back(v);
    if (!v.retentive_en_n) begin
      v.retentive_en_n = 1'b1;
      exp_q.push_back(v);
    end
    v.isogate_en_n = 1'b1;
    exp_q.push_back(v);
    v.clkgate_en_n = 1'b1;
    exp_q.push_back(v);
  endtask

  // each change of the domain's controls must be the next expected one
  task automatic follow_ctrl(input int dom);
    pwr_ctrl_out_t prev;
    int            cycles;
    prev   = pwr_ctrl[dom];
    cycles = 0;
    while (exp_q.size() > 0) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("timeout waiting for control changes of domain %0d", dom));
      end
      if (pwr_ctrl[dom] !== prev) begin
        check($sformatf("pwr_ctrl_o[%0d]", dom), pwr_ctrl[dom], exp_q.pop_front());
        prev = pwr_ctrl[dom];
      end
    end
  endtask

  task automatic wait_ctrl(input int dom, input pwr_ctrl_out_t exp);
    int cycles;
    cycles = 0;
    while (pwr_ctrl[dom] !== exp) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("timeout waiting for domain %0d to settle", dom));
      end
    end
  endtask

  task automatic wait_credits();
    int cycles;
    cycles = 0;
    while (credits_back != pushes_sent) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout waiting for all credits to return");
      end
    end
  endtask

  task automatic send_cmd(input int dom, input pwr_op_e op);
    int cycles;
    cycles = 0;
    while ((CMD_DEPTH - pushes_sent + credits_back) <= 0) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout waiting for a free command credit");
      end
    end
    cmd.dom   = DOM_W'(dom);
    cmd.op    = op;
    cmd_valid = 1'b1;
    pushes_sent++;
    step();
    cmd_valid = 1'b0;
  endtask

  // 0 software, 1 timer 0, 2 external, 3 to 16 the fast lines in order
  task automatic set_source(input int src, input logic val);
    case (src)
      0: irq_software = val;
      1: timer_intr[0] = val;
      2: irq_external = val;
      3, 4, 5: timer_intr[src - 2] = val;
      6: dma_done_intr = val;
      7: spi_intr = val;
      8: spi_flash_intr = val;
      default: gpio_ao_intr[src - 9] = val;
    endcase
  endtask

  function automatic int source_bit(input int src);
    case (src)
      0: return IRQ_SW_BIT;
      1: return IRQ_TIMER_BIT;
      2: return IRQ_EXT_BIT;
      default: return IRQ_FAST_BASE + src - 3;
    endcase
  endfunction

  task automatic test_reset();
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      check($sformatf("pwr_ctrl_o[%0d]", d), pwr_ctrl[d], 5'h1f);
    end
    check("irq_o", irq, '0);
    check("credit_o", credit, 1'b0);
  endtask

  task automatic test_power_cycle();
    expect_power_down(1'b0);
    send_cmd(DOM_PERIPH, PWR_OFF);
    follow_ctrl(DOM_PERIPH);
    expect_power_up(settled(PWR_OFF, 1'b0));
    send_cmd(DOM_PERIPH, PWR_ON);
    follow_ctrl(DOM_PERIPH);
  endtask

  task automatic test_retain();
    expect_power_down(1'b1);
    send_cmd(DOM_PERIPH + 1, PWR_RETAIN);
    follow_ctrl(DOM_PERIPH + 1);
    // switch must stay on for a retained bank
    repeat (10) step();
    check("pwr_ctrl_o[2]", pwr_ctrl[DOM_PERIPH + 1], settled(PWR_RETAIN, 1'b1));
    expect_power_up(settled(PWR_RETAIN, 1'b1));
    send_cmd(DOM_PERIPH + 1, PWR_ON);
    follow_ctrl(DOM_PERIPH + 1);
    // no retention on the peripheral domain
    expect_power_down(1'b0);
    send_cmd(DOM_PERIPH, PWR_RETAIN);
    follow_ctrl(DOM_PERIPH);
    expect_power_up(settled(PWR_OFF, 1'b0));
    send_cmd(DOM_PERIPH, PWR_ON);
    follow_ctrl(DOM_PERIPH);
  endtask

  task automatic test_credits();
    pwr_op_e ops [NUM_BANKS];
    wait_credits();
    for (int b = 0; b < NUM_BANKS; b++) begin
      ops[b] = (b % 2) ? PWR_RETAIN : PWR_OFF;
      send_cmd(DOM_PERIPH + 1 + b, ops[b]);
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      wait_ctrl(DOM_PERIPH + 1 + b, settled(ops[b], 1'b1));
    end
    // every command has left the FIFO once its bank has settled
    check("credit_o", credits_back, pushes_sent);
    for (int b = 0; b < NUM_BANKS; b++) begin
      send_cmd(DOM_PERIPH + 1 + b, PWR_ON);
    end
    wait_credits();
    for (int b = 0; b < NUM_BANKS; b++) begin
      wait_ctrl(DOM_PERIPH + 1 + b, settled(PWR_ON, 1'b1));
    end
  endtask

  task automatic test_irq();
    int pos;
    for (int s = 0; s < 17; s++) begin
      pos = source_bit(s);
      set_source(s, 1'b1);
      step();
      check("irq_o", irq, 32'h1 << pos);
      set_source(s, 1'b0);
      step();
      if (s < 3) begin
        check("irq_o", irq, '0);
      end else begin
        check("irq_o", irq, 32'h1 << pos);
        // a wrong id leaves the line pending
        irq_ack = 1'b1;
        irq_id  = 5'(pos + 1);
        step();
        irq_ack = 1'b0;
        check("irq_o", irq, 32'h1 << pos);
        irq_ack = 1'b1;
        irq_id  = 5'(pos);
        step();
        irq_ack = 1'b0;
        check("irq_o", irq, '0);
      end
    end
  endtask

  task automatic test_wake();
    int cycles;
    expect_power_down(1'b0);
    send_cmd(DOM_CPU, PWR_OFF);
    follow_ctrl(DOM_CPU);
    cycles = 0;
    while (pwr_ack_n[DOM_CPU] !== 1'b0) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout waiting for the cpu switch to turn off");
      end
    end
    wait_credits();
    repeat (2) step();
    expect_power_up(settled(PWR_OFF, 1'b0));
    set_source(1, 1'b1);
    follow_ctrl(DOM_CPU);
    set_source(1, 1'b0);
    step();
    check("irq_o", irq, '0);
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    cmd            = '0;
    cmd_valid      = 1'b0;
    irq_software   = 1'b0;
    irq_external   = 1'b0;
    timer_intr     = '0;
    dma_done_intr  = 1'b0;
    spi_intr       = 1'b0;
    spi_flash_intr = 1'b0;
    gpio_ao_intr   = '0;
    irq_ack        = 1'b0;
    irq_id         = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset();
    test_power_cycle();
    test_retain();
    test_credits();
    test_irq();
    test_wake();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
source/pwr_pkg.sv
source/intr_aggregator.sv
source/pwr_cmd_fifo.sv
source/domain_sequencer.sv
source/power_manager.sv
source/mcu_ao_top.sv
test/tb_mcu_ao_top.sv

//--- Bender.yml
package:
  name: mcu_ao

sources:
  - source/pwr_pkg.sv
  - source/intr_aggregator.sv
  - source/pwr_cmd_fifo.sv
  - source/domain_sequencer.sv
  - source/power_manager.sv
  - source/mcu_ao_top.sv
  - target: test
    files:
      - test/tb_mcu_ao_top.sv
